/* source/periph_map_pkg.sv */
package periph_map_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Default region bases
    localparam logic [ADDR_W-1:0] TIMER_BASE_DEF = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] UART_BASE_DEF  = 32'h4000_2000;

    // Region sizes in bytes
    localparam int TIMER_SIZE = 4096;
    localparam int UART_SIZE  = 8192;

    localparam int UART_OFFS_W = 13;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_TIMER,
        REGION_UART
    } region_e;

    // Timer register byte offsets
    localparam logic [ADDR_W-1:0] TIMER_MTIME_LO = 32'h0;
    localparam logic [ADDR_W-1:0] TIMER_MTIME_HI = 32'h4;
    localparam logic [ADDR_W-1:0] TIMER_CMP_LO   = 32'h8;
    localparam logic [ADDR_W-1:0] TIMER_CMP_HI   = 32'hC;

endpackage

/* source/periph_bus_pkg.sv */
package periph_bus_pkg;

    import periph_map_pkg::*;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic              pready;
        logic [DATA_W-1:0] prdata;
        logic              pslverr;
    } apb_rsp_t;

    // Timer sees whole words, low bits ignored
    typedef struct packed {
        logic [ADDR_W-3:0] word_idx;
        logic [1:0]        byte_sel;
    } timer_offs_t;

    typedef struct packed {
        logic [ADDR_W-UART_OFFS_W-1:0] unused;
        logic [UART_OFFS_W-1:0]        byte_offs;
    } uart_offs_t;

    // Same local offset, decoded per target
    typedef union packed {
        timer_offs_t timer;
        uart_offs_t  uart;
    } offs_u;

    typedef struct packed {
        logic              sel;
        logic              penable;
        logic              pwrite;
        offs_u             offset;
        logic [DATA_W-1:0] pwdata;
    } tgt_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [UART_OFFS_W-1:0] addr;
        logic [DATA_W-1:0]      wdata;
    } uart_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] rdata;
        logic              error;
    } uart_rsp_t;

endpackage

/* source/periph_decoder.sv */
module periph_decoder
    import periph_map_pkg::*;
    import periph_bus_pkg::*;
#(
    parameter logic [ADDR_W-1:0] TIMER_BASE = TIMER_BASE_DEF,
    parameter logic [ADDR_W-1:0] UART_BASE  = UART_BASE_DEF
) (
    input  apb_req_t req_i,
    output tgt_req_t timer_o,
    output tgt_req_t uart_o,
    output region_e  region_o
);

    logic [ADDR_W-1:0] timer_offs;
    logic [ADDR_W-1:0] uart_offs;
    logic              timer_hit;
    logic              uart_hit;

    // Wrapping subtract, so one compare covers both range ends
    assign timer_offs = req_i.paddr - TIMER_BASE;
    assign uart_offs  = req_i.paddr - UART_BASE;
    assign timer_hit  = timer_offs < ADDR_W'(TIMER_SIZE);
    assign uart_hit   = uart_offs < ADDR_W'(UART_SIZE);

    assign timer_o.sel     = req_i.psel && timer_hit;
    assign timer_o.penable = req_i.penable;
    assign timer_o.pwrite  = req_i.pwrite;
    assign timer_o.offset  = offs_u'(timer_offs);
    assign timer_o.pwdata  = req_i.pwdata;

    assign uart_o.sel     = req_i.psel && uart_hit;
    assign uart_o.penable = req_i.penable;
    assign uart_o.pwrite  = req_i.pwrite;
    assign uart_o.offset  = offs_u'(uart_offs);
    assign uart_o.pwdata  = req_i.pwdata;

    always_comb begin
        region_o = REGION_NONE;
        if (req_i.psel && timer_hit) begin
            region_o = REGION_TIMER;
        end else if (req_i.psel && uart_hit) begin
            region_o = REGION_UART;
        end
    end

    // Overlapping bases from the top level would select both targets
    a_one_target: assert property (@(posedge req_i.penable) !(timer_o.sel && uart_o.sel));

endmodule

/* source/machine_timer.sv */
module machine_timer
    import periph_map_pkg::*;
    import periph_bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  tgt_req_t req_i,
    output apb_rsp_t rsp_o,
    output logic     irq_o
);

    logic [63:0]       mtime_q;
    logic [63:0]       mtimecmp_q;
    logic              access;
    logic [ADDR_W-1:0] reg_offs;
    logic [DATA_W-1:0] rdata;
    logic              known;

    assign access = req_i.sel && req_i.penable;

    // Byte select bits are don't-care
    assign reg_offs = {req_i.offset.timer.word_idx, 2'b00};

    always_comb begin
        rdata = '0;
        known = 1'b1;
        case (reg_offs)
            TIMER_MTIME_LO: rdata = mtime_q[31:0];
            TIMER_MTIME_HI: rdata = mtime_q[63:32];
            TIMER_CMP_LO:   rdata = mtimecmp_q[31:0];
            TIMER_CMP_HI:   rdata = mtimecmp_q[63:32];
            default:        known = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
        end else begin
            mtime_q <= mtime_q + 64'd1;
            if (access && req_i.pwrite) begin
                // A half write replaces that cycle's increment
                case (reg_offs)
                    TIMER_MTIME_LO: mtime_q <= {mtime_q[63:32], req_i.pwdata};
                    TIMER_MTIME_HI: mtime_q <= {req_i.pwdata, mtime_q[31:0]};
                    TIMER_CMP_LO:   mtimecmp_q[31:0] <= req_i.pwdata;
                    TIMER_CMP_HI:   mtimecmp_q[63:32] <= req_i.pwdata;
                    default:        ;
                endcase
            end
        end
    end

    assign irq_o = mtime_q >= mtimecmp_q;

    // Zero wait states
    assign rsp_o.pready  = access;
    assign rsp_o.prdata  = (access && !req_i.pwrite) ? rdata : '0;
    assign rsp_o.pslverr = access && !known;

    // Completion only after a proper setup phase
    a_setup_before_ready: assert property (
        @(posedge clk_i) disable iff (rst_i)
        rsp_o.pready |-> req_i.penable && $past(req_i.sel && !req_i.penable)
    );

endmodule

/* source/uart_bridge.sv */
module uart_bridge
    import periph_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  tgt_req_t  req_i,
    output apb_rsp_t  rsp_o,
    output uart_req_t uart_req_o,
    input  uart_rsp_t uart_rsp_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   access;
    logic   start;
    logic   done;
    logic [$bits(uart_rsp_i.rdata)-1:0] rdata_q;
    logic   err_q;

    assign access = req_i.sel && req_i.penable;
    assign start  = (state_q == ST_IDLE) && access;
    assign done   = state_q == ST_DONE;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (access) begin
                    state_d = uart_rsp_i.valid ? ST_DONE : ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (uart_rsp_i.valid) begin
                    state_d = ST_DONE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (uart_req_o.valid && uart_rsp_i.valid) begin
            rdata_q <= uart_rsp_i.rdata;
            err_q   <= uart_rsp_i.error;
        end
    end

    // Host holds address and data, so the payload follows it
    assign uart_req_o.valid = start || (state_q == ST_WAIT);
    assign uart_req_o.write = req_i.pwrite;
    assign uart_req_o.addr  = req_i.offset.uart.byte_offs;
    assign uart_req_o.wdata = req_i.pwdata;

    assign rsp_o.pready  = done;
    assign rsp_o.prdata  = done ? rdata_q : '0;
    assign rsp_o.pslverr = done && err_q;

    a_req_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        state_q == ST_WAIT |-> $stable(uart_req_o)
    );

endmodule

/* source/periph_resp_mux.sv */
module periph_resp_mux
    import periph_map_pkg::*;
    import periph_bus_pkg::*;
(
    input  region_e    region_i,
    input  logic       penable_i,
    input  apb_rsp_t   timer_rsp_i,
    input  apb_rsp_t   uart_rsp_i,
    input  logic       timer_irq_i,
    input  logic       uart_irq_i,
    output apb_rsp_t   rsp_o,
    output logic [1:0] irq_o
);

    always_comb begin
        case (region_i)
            REGION_TIMER: rsp_o = timer_rsp_i;
            REGION_UART:  rsp_o = uart_rsp_i;
            default: begin
                // Unmapped, error in the first access cycle
                rsp_o.pready  = penable_i;
                rsp_o.prdata  = '0;
                rsp_o.pslverr = penable_i;
            end
        endcase
    end

    assign irq_o = {uart_irq_i, timer_irq_i};

endmodule

/* source/periph_subsystem.sv */
module periph_subsystem
    import periph_map_pkg::*;
    import periph_bus_pkg::*;
#(
    parameter logic [ADDR_W-1:0] TIMER_BASE = TIMER_BASE_DEF,
    parameter logic [ADDR_W-1:0] UART_BASE  = UART_BASE_DEF
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  apb_req_t   apb_req_i,
    output apb_rsp_t   apb_rsp_o,
    output uart_req_t  uart_req_o,
    input  uart_rsp_t  uart_rsp_i,
    input  logic       uart_irq_i,
    output logic [1:0] irq_o
);

    tgt_req_t timer_req;
    tgt_req_t uart_tgt_req;
    region_e  region;
    apb_rsp_t timer_rsp;
    apb_rsp_t uart_tgt_rsp;
    logic     timer_irq;

    periph_decoder #(
        .TIMER_BASE(TIMER_BASE),
        .UART_BASE (UART_BASE)
    ) u_decoder (
        .req_i   (apb_req_i),
        .timer_o (timer_req),
        .uart_o  (uart_tgt_req),
        .region_o(region)
    );

    machine_timer u_timer (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .req_i(timer_req),
        .rsp_o(timer_rsp),
        .irq_o(timer_irq)
    );

    uart_bridge u_uart_bridge (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (uart_tgt_req),
        .rsp_o     (uart_tgt_rsp),
        .uart_req_o(uart_req_o),
        .uart_rsp_i(uart_rsp_i)
    );

    periph_resp_mux u_resp_mux (
        .region_i   (region),
        .penable_i  (apb_req_i.penable),
        .timer_rsp_i(timer_rsp),
        .uart_rsp_i (uart_tgt_rsp),
        .timer_irq_i(timer_irq),
        .uart_irq_i (uart_irq_i),
        .rsp_o      (apb_rsp_o),
        .irq_o      (irq_o)
    );

endmodule

/* verif/periph_tests.svh */
`ifndef PERIPH_TESTS_SVH
`define PERIPH_TESTS_SVH

    task automatic reset_defaults();
        int          errs;
        logic [31:0] data;
        logic        err;
        errs = error_count;
        check_equal("pready", 32'(apb_rsp.pready), 32'd0);
        check_equal("irq", 32'(irq), 32'd0);
        check_equal("uart_req.valid", 32'(uart_req.valid), 32'd0);
        apb_read(TIMER_BASE_DEF + TIMER_CMP_LO, data, err);
        check_equal("mtimecmp_lo", data, 32'hFFFF_FFFF);
        apb_read(TIMER_BASE_DEF + TIMER_CMP_HI, data, err);
        check_equal("mtimecmp_hi", data, 32'hFFFF_FFFF);
        check_equal("pslverr", 32'(err), 32'd0);
        report_test("reset_defaults", errs);
    endtask

    task automatic timer_register_access();
        int          errs;
        logic [31:0] data;
        logic        err;
        errs = error_count;
        apb_write(TIMER_BASE_DEF + TIMER_MTIME_HI, 32'd0, err);
        apb_write(TIMER_BASE_DEF + TIMER_MTIME_LO, 32'd100, err);
        apb_read(TIMER_BASE_DEF + TIMER_MTIME_LO, data, err);
        if (data <= 32'd100 || data >= 32'd200) begin
            $display("ERROR: mtime_lo is %h, expected between %h and %h",
                     data, 32'd100, 32'd200);
            error_count++;
        end
        apb_write(TIMER_BASE_DEF + TIMER_CMP_LO, 32'h1357_9BDF, err);
        apb_write(TIMER_BASE_DEF + TIMER_CMP_HI, 32'h0246_8ACE, err);
        check_equal("pslverr", 32'(err), 32'd0);
        apb_read(TIMER_BASE_DEF + TIMER_CMP_LO, data, err);
        check_equal("mtimecmp_lo", data, 32'h1357_9BDF);
        apb_read(TIMER_BASE_DEF + TIMER_CMP_HI, data, err);
        check_equal("mtimecmp_hi", data, 32'h0246_8ACE);
        // No register behind offset 0x10
        apb_read(TIMER_BASE_DEF + 32'h10, data, err);
        check_equal("pslverr", 32'(err), 32'd1);
        report_test("timer_register_access", errs);
    endtask

    task automatic timer_interrupt();
        int   errs;
        int   cycles;
        logic err;
        errs = error_count;
        apb_write(TIMER_BASE_DEF + TIMER_CMP_HI, 32'hFFFF_FFFF, err);
        apb_write(TIMER_BASE_DEF + TIMER_MTIME_HI, 32'd0, err);
        apb_write(TIMER_BASE_DEF + TIMER_MTIME_LO, 32'd0, err);
        apb_write(TIMER_BASE_DEF + TIMER_CMP_LO, 32'd50, err);
        apb_write(TIMER_BASE_DEF + TIMER_CMP_HI, 32'd0, err);
        check_equal("irq[0]", 32'(irq[0]), 32'd0);
        cycles = 0;
        while (!irq[0] && cycles < 200) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!irq[0]) begin
            $display("timer interrupt did not rise within 200 cycles");
            error_count++;
        end
        apb_write(TIMER_BASE_DEF + TIMER_CMP_HI, 32'hFFFF_FFFF, err);
        apb_write(TIMER_BASE_DEF + TIMER_CMP_LO, 32'hFFFF_FFFF, err);
        check_equal("irq[0]", 32'(irq[0]), 32'd0);
        report_test("timer_interrupt", errs);
    endtask

    task automatic uart_forwarding();
        int          errs;
        int          count;
        logic [31:0] rnd;
        logic [12:0] offs;
        logic [31:0] data;
        logic        is_write;
        logic        err;
        errs = error_count;
        // Directed write and read back at 0x10, then random accesses
        for (int i = 0; i < 12; i++) begin
            rnd         = $random(seed);
            data        = $random(seed);
            reply_delay = 3'($unsigned($random(seed)) % 6);
            offs        = (i < 2) ? 13'h10 : {6'd0, rnd[6:2], 2'b00};
            is_write    = (i == 0) || (i >= 2 && rnd[8]);
            count       = req_count;
            if (i == 0) begin
                data = 32'hC0FF_EE01;
            end
            if (is_write) begin
                apb_write(UART_BASE_DEF + 32'(offs), data, err);
                check_equal("uart_mem", uart_mem[offs[6:2]], data);
                check_equal("uart_req.wdata", seen.wdata, data);
            end else begin
                apb_read(UART_BASE_DEF + 32'(offs), data, err);
                check_equal("prdata", data, uart_mem[offs[6:2]]);
            end
            check_equal("uart_req.addr", 32'(seen.addr), 32'(offs));
            check_equal("uart_req.write", 32'(seen.write), 32'(is_write));
            check_equal("uart request count", req_count, count + 1);
            check_equal("pslverr", 32'(err), 32'd0);
        end
        count = req_count;
        apb_read(UART_BASE_DEF + 32'h1800, data, err);
        check_equal("pslverr", 32'(err), 32'd1);
        check_equal("uart request count", req_count, count + 1);
        report_test("uart_forwarding", errs);
    endtask

    task automatic unmapped_access();
        int          errs;
        int          count;
        logic [31:0] cmp_before;
        logic [31:0] mem_before;
        logic [31:0] data;
        logic        err;
        errs = error_count;
        apb_read(TIMER_BASE_DEF + TIMER_CMP_LO, cmp_before, err);
        apb_read(UART_BASE_DEF + 32'h10, mem_before, err);
        count = req_count;
        // Addresses that alias real registers if the upper bits were dropped
        apb_write(TIMER_BASE_DEF + 32'h1008, 32'h0BAD_0BAD, err);
        check_equal("pslverr", 32'(err), 32'd1);
        apb_write(UART_BASE_DEF + 32'h2010, 32'h0BAD_0BAD, err);
        check_equal("pslverr", 32'(err), 32'd1);
        apb_read(TIMER_BASE_DEF - 32'h4, data, err);
        check_equal("pslverr", 32'(err), 32'd1);
        check_equal("prdata", data, 32'd0);
        check_equal("uart request count", req_count, count);
        apb_read(TIMER_BASE_DEF + TIMER_CMP_LO, data, err);
        check_equal("mtimecmp_lo", data, cmp_before);
        apb_read(UART_BASE_DEF + 32'h10, data, err);
        check_equal("uart_mem", data, mem_before);
        report_test("unmapped_access", errs);
    endtask

    task automatic uart_interrupt_input();
        int errs;
        errs = error_count;
        @(negedge clk_i);
        uart_irq = 1'b1;
        @(negedge clk_i);
        check_equal("irq", 32'(irq), 32'h2);
        uart_irq = 1'b0;
        @(negedge clk_i);
        check_equal("irq", 32'(irq), 32'h0);
        report_test("uart_interrupt_input", errs);
    endtask

`endif

/* verif/periph_tb.sv */
module periph_tb
    import periph_map_pkg::*;
    import periph_bus_pkg::*;
();

    logic        clk_i = 1'b0;
    logic        rst_i;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    uart_req_t   uart_req;
    uart_rsp_t   uart_rsp = '0;
    logic        uart_irq;
    logic [1:0]  irq;
    integer      seed = 32'ha099_eba0;
    int          error_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;

    // UART responder model
    logic [31:0] uart_mem [0:31];
    logic [2:0]  reply_delay = '0;
    logic [2:0]  wait_cnt;
    logic        busy;
    uart_req_t   seen;
    uart_rsp_t   reply;
    int          req_count;

    always #20 clk_i = ~clk_i;

    periph_subsystem #(
        .TIMER_BASE(TIMER_BASE_DEF),
        .UART_BASE (UART_BASE_DEF)
    ) u_periph_subsystem (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .uart_req_o(uart_req),
        .uart_rsp_i(uart_rsp),
        .uart_irq_i(uart_irq),
        .irq_o     (irq)
    );

    // Offsets from 0x1000 up answer with an error
    always @(posedge clk_i) begin
        if (rst_i) begin
            busy      <= 1'b0;
            reply     <= '0;
            req_count <= 0;
            for (int i = 0; i < 32; i++) begin
                uart_mem[5'(i)] <= 32'h5EED_0000 ^ (32'(i) * 32'h0004_0001);
            end
        end else if (reply.valid) begin
            reply.valid <= 1'b0;
            busy        <= 1'b0;
        end else if (busy && wait_cnt != 3'd0) begin
            wait_cnt <= wait_cnt - 3'd1;
        end else if (busy) begin
            reply.valid <= 1'b1;
            reply.error <= seen.addr >= 13'h1000;
            reply.rdata <= uart_mem[seen.addr[6:2]];
            if (seen.write && seen.addr < 13'h1000) begin
                uart_mem[seen.addr[6:2]] <= seen.wdata;
            end
        end else if (uart_req.valid) begin
            busy      <= 1'b1;
            wait_cnt  <= reply_delay;
            seen      <= uart_req;
            req_count <= req_count + 1;
        end
    end

    always @(negedge clk_i) begin
        uart_rsp = reply;
    end

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    // pready and read data are sampled on the falling edge
    task automatic apb_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: is_write,
                    paddr: addr, pwdata: wdata};
        @(negedge clk_i);
        apb_req.penable = 1'b1;
        @(negedge clk_i);
        while (!apb_rsp.pready && cycles < 64) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!apb_rsp.pready) begin
            $display("APB access to %h never completed", addr);
            error_count++;
        end
        rdata   = apb_rsp.prdata;
        err     = apb_rsp.pslverr;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] ignored;
        apb_access(1'b1, addr, data, ignored, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        apb_access(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed", name);
            failed_tests++;
        end
    endtask

    `include "periph_tests.svh"

    initial begin
        rst_i    = 1'b1;
        apb_req  = '0;
        uart_irq = 1'b0;
        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;
        reset_defaults();
        timer_register_access();
        timer_interrupt();
        uart_forwarding();
        unmapped_access();
        uart_interrupt_input();
        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verif
source/periph_map_pkg.sv
source/periph_bus_pkg.sv
source/periph_decoder.sv
source/machine_timer.sv
source/uart_bridge.sv
source/periph_resp_mux.sv
source/periph_subsystem.sv
verif/periph_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= periph_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
